/* Bender.yml */
package:
  name: uart_link

sources:
  - uart_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_stats.sv
  - uart_link.sv
  - target: simulation
    files:
      - tb_uart_link.sv

/* sim.f */
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_stats.sv
uart_link.sv
tb_uart_link.sv

/* tb_uart_link.sv */
// testbench with random loopback and driven frames, model, checks and watchdog
`default_nettype none

module tb_uart_link import uart_pkg::*; ();

    localparam int cnt_w      = 4;  // small so saturation comes quickly
    localparam int cnt_max    = (1 << cnt_w) - 1;
    localparam int frame_bits = data_w + 2;
    localparam int n_loop     = 18;
    localparam int n_drv      = 20;
    localparam int max_div    = 10;
    localparam int limit      = (n_loop + n_drv) * (frame_bits * (max_div + 1) + 30) + 1000;

    logic              clk;
    logic              rst_n;
    logic [baud_w-1:0] baud_div;
    logic              start_tx;
    logic [data_w-1:0] data_in;
    logic              tx_pin;
    logic              tx_started;
    logic              tx_done;
    logic              rx_pin;
    logic [data_w-1:0] rx_data;
    logic              rx_valid;
    logic              rx_frame_err;
    logic              stats_clr;
    logic [cnt_w-1:0]  tx_count;
    logic [cnt_w-1:0]  rx_count;
    logic [cnt_w-1:0]  err_count;
    logic              loop_en;     // rx_pin follows tx_pin
    logic              drv_pin;     // serial driver output
    logic [31:0]       rng = 32'heb50;
    int                exp_q[$];    // expected bytes with -1 for a framing error
    int                exp_tx = 0;
    int                exp_rx = 0;
    int                exp_err = 0;

    assign rx_pin = loop_en ? tx_pin : drv_pin;

    uart_link #(.CNT_W(cnt_w)) uut (
        .clk(clk), .rst_n(rst_n), .baud_div(baud_div), .start_tx(start_tx),
        .data_in(data_in), .tx_pin(tx_pin), .tx_started(tx_started), .tx_done(tx_done),
        .rx_pin(rx_pin), .rx_data(rx_data), .rx_valid(rx_valid),
        .rx_frame_err(rx_frame_err), .stats_clr(stats_clr), .tx_count(tx_count),
        .rx_count(rx_count), .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int bump(input int c);
        return (c < cnt_max) ? c + 1 : c; // counters hold at all ones
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
            stop_run("value mismatch");
        end
    endtask

    // receiver strobes against the queue
    always @(negedge clk) begin
        int e;
        if (rst_n && (rx_valid || rx_frame_err)) begin
            if (exp_q.size() == 0) begin
                stop_run("receiver produced a result with no frame in flight");
            end else begin
                e = exp_q.pop_front();
                check("rx_valid", e >= 0, rx_valid);
                check("rx_frame_err", e < 0, rx_frame_err);
                if (rx_valid) begin
                    check("rx_data", e, rx_data);
                    exp_rx = bump(exp_rx);
                end else begin
                    exp_err = bump(exp_err);
                end
            end
        end
    end

    task automatic idle_gap();
        rng = xorshift(rng);
        repeat (2 + int'(rng % 8)) @(posedge clk);
    endtask

    // sends one looped-back frame and pokes a strobe while busy
    task automatic send_loopback(input logic [data_w-1:0] b, input int bt);
        int cyc;
        int i;
        int poke;
        logic exp_bit;
        rng = xorshift(rng);
        poke = 2 + int'(rng % (8 * bt));
        exp_q.push_back(int'(b));
        @(posedge clk);
        start_tx <= 1'b1;
        data_in  <= b;
        @(posedge clk);
        start_tx <= 1'b0;
        cyc = 1;
        @(negedge clk);
        while (!tx_done) begin
            i = (cyc - 1) / bt;
            if ((cyc - 1) % bt == bt / 2) begin
                exp_bit = (i == 0) ? 1'b0 : (i == frame_bits - 1) ? 1'b1 : b[i-1];
                check("tx_pin", exp_bit, tx_pin);
                check("tx_started", 1, tx_started);
            end
            @(posedge clk);
            cyc++;
            start_tx <= (cyc == poke); // must be dropped, frame in flight
            data_in  <= ~b;
            @(negedge clk);
        end
        check("tx_done delay", frame_bits * bt + 1, cyc);
        exp_tx = bump(exp_tx); // one frame sent
        while (exp_q.size() != 0) @(negedge clk);
        idle_gap();
        @(negedge clk);
        check("tx_started", 0, tx_started);
        check("tx_done", 1, tx_done);
    endtask

    task automatic drive_serial(input logic [data_w-1:0] b, input logic stop_ok, input int bt);
        logic [frame_bits-1:0] bits;
        int i;
        bits = {stop_ok, b, 1'b0};
        if (stop_ok) exp_q.push_back(int'(b));
        else exp_q.push_back(-1);
        @(posedge clk);
        for (i = 0; i < frame_bits; i++) begin
            drv_pin <= bits[i];
            repeat (bt) @(posedge clk);
        end
        drv_pin <= 1'b1;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic drive_glitch(input int bd);
        int g;
        rng = xorshift(rng);
        g = 1 + int'(rng % (bd >> 1)); // under half a bit
        @(posedge clk);
        drv_pin <= 1'b0;
        repeat (g) @(posedge clk);
        drv_pin <= 1'b1;
        repeat (bd + 8) @(posedge clk);
    endtask

    task automatic check_counts();
        repeat (2) @(negedge clk);
        check("tx_count", exp_tx, tx_count);
        check("rx_count", exp_rx, rx_count);
        check("err_count", exp_err, err_count);
    endtask

    task automatic clear_stats();
        @(posedge clk);
        stats_clr <= 1'b1;
        @(posedge clk);
        stats_clr <= 1'b0;
        exp_tx  = 0;
        exp_rx  = 0;
        exp_err = 0;
        check_counts();
    endtask

    initial begin
        repeat (limit) @(posedge clk);
        stop_run("watchdog expired, the run timed out before all frames completed");
    end

    initial begin
        int n;
        int bd;
        rst_n     = 1'b0;
        baud_div  = baud_w'(3);
        start_tx  = 1'b0;
        data_in   = '0;
        stats_clr = 1'b0;
        loop_en   = 1'b1;
        drv_pin   = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("tx_pin", 1, tx_pin);
        check("tx_done", 1, tx_done);
        check("tx_started", 0, tx_started);
        check("rx_valid", 0, rx_valid);
        check("rx_frame_err", 0, rx_frame_err);
        check_counts();
        rng = xorshift(rng);
        bd = 3 + int'(rng % 8);
        @(posedge clk);
        baud_div <= baud_w'(bd);
        for (n = 0; n < n_loop; n++) begin
            rng = xorshift(rng);
            send_loopback(rng[data_w-1:0], bd + 1);
        end
        check_counts();
        clear_stats();
        // driven line with most stop bits broken so err_count saturates
        rng = xorshift(rng);
        bd = 3 + int'(rng % 8);
        @(posedge clk);
        baud_div <= baud_w'(bd);
        loop_en  <= 1'b0;
        for (n = 0; n < n_drv; n++) begin
            rng = xorshift(rng);
            drive_serial(rng[data_w-1:0], (n % 5) == 0, bd + 1);
            if (n % 4 == 1) drive_glitch(bd);
            idle_gap();
        end
        check_counts();
        clear_stats();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_link.sv */
// top level with transmitter, receiver and statistics side by side
`default_nettype none

module uart_link import uart_pkg::*; #(
    parameter int CNT_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [baud_w-1:0] baud_div,   // bit time shared by both sides
    input  logic              start_tx,
    input  logic [data_w-1:0] data_in,
    output logic              tx_pin,
    output logic              tx_started,
    output logic              tx_done,
    input  logic              rx_pin,
    output logic [data_w-1:0] rx_data,
    output logic              rx_valid,
    output logic              rx_frame_err,
    input  logic              stats_clr,
    output logic [CNT_W-1:0]  tx_count,
    output logic [CNT_W-1:0]  rx_count,
    output logic [CNT_W-1:0]  err_count
);

    uart_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .baud_div   (baud_div),
        .start_tx   (start_tx),
        .data_in    (data_in),
        .tx_pin     (tx_pin),
        .tx_started (tx_started),
        .tx_done    (tx_done)
    );

    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .baud_div     (baud_div),
        .rx_pin       (rx_pin),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    // results of both directions meet here
    uart_stats #(
        .CNT_W (CNT_W)
    ) u_stats (
        .clk          (clk),
        .rst_n        (rst_n),
        .stats_clr    (stats_clr),
        .tx_done      (tx_done),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err),
        .tx_count     (tx_count),
        .rx_count     (rx_count),
        .err_count    (err_count)
    );

endmodule

`default_nettype wire

/* uart_pkg.sv */
// divider and character widths, frame phase type
`default_nettype none

package uart_pkg;

    // bit time is baud_div+1 clock cycles
    localparam int baud_w = 16; // divider width
    localparam int data_w = 8;  // one 8N1 character

    // phase of a frame in either direction
    typedef enum logic [1:0] {
        st_idle  = 2'd0, // line high and nothing in flight
        st_start = 2'd1, // start bit with line low
        st_data  = 2'd2, // data bits from lsb
        st_stop  = 2'd3  // stop bit with line high
    } uart_state_t;

endpackage

`default_nettype wire

/* uart_rx.sv */
// 8N1 receiver with line synchronizer, mid-bit sampling and result strobes
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [baud_w-1:0] baud_div,     // bit time minus one
    input  logic              rx_pin,       // asynchronous serial line
    output logic [data_w-1:0] rx_data,
    output logic              rx_valid,     // good frame for one cycle
    output logic              rx_frame_err  // stop bit low for one cycle
);

    localparam int idx_w = $clog2(data_w);

    logic              rx_meta;   // first synchronizer stage
    logic              rx_sync;   // second stage, safe to use
    logic              rx_prev;   // for edge detection
    logic              fall_edge;
    uart_state_t       state;
    logic [baud_w-1:0] bit_timer;
    logic [idx_w-1:0]  bit_idx;
    logic [data_w-1:0] shift_reg;
    logic              sample;    // mid-bit sample point

    assign fall_edge = rx_prev && !rx_sync;
    assign sample    = (bit_timer == '0);

    // synchronizer stages and edge history
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // bits arrive lsb first and shift in from the top
    always_ff @(posedge clk) begin
        if (state == st_data && sample) begin
            shift_reg <= {rx_sync, shift_reg[data_w-1:1]};
        end
        if (state == st_stop && sample && rx_sync) begin
            rx_data <= shift_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= st_idle;
            bit_timer    <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                st_idle: begin
                    if (fall_edge) begin
                        state     <= st_start;
                        bit_timer <= baud_div >> 1; // half a bit to mid start
                    end
                end
                st_start: begin
                    if (sample) begin
                        if (!rx_sync) begin
                            state     <= st_data;
                            bit_timer <= baud_div;
                            bit_idx   <= '0;
                        end else begin
                            state <= st_idle; // glitch gives no frame
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                st_data: begin
                    if (sample) begin
                        bit_timer <= baud_div;
                        if (bit_idx == idx_w'(data_w - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                st_stop: begin
                    if (sample) begin
                        state        <= st_idle;
                        rx_valid     <= rx_sync;
                        rx_frame_err <= !rx_sync;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a frame ends in exactly one result
    a_result_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_valid && rx_frame_err));

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_frame_err |=> !rx_frame_err);

endmodule

`default_nettype wire

/* uart_stats.sv */
// saturating counters of sent frames, good frames and framing errors
`default_nettype none

module uart_stats #(
    parameter int CNT_W = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stats_clr,    // zeros all counters ahead of events
    input  logic             tx_done,
    input  logic             rx_valid,
    input  logic             rx_frame_err,
    output logic [CNT_W-1:0] tx_count,
    output logic [CNT_W-1:0] rx_count,
    output logic [CNT_W-1:0] err_count
);

    logic tx_done_q;  // previous tx_done
    logic tx_event;   // end of a sent frame

    assign tx_event = tx_done && !tx_done_q;

    // holds at all ones instead of wrapping
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt,
                                                 input logic             ev);
        if (ev && (cnt != '1)) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_done_q <= 1'b1; // tx_done is high out of reset
            tx_count  <= '0;
            rx_count  <= '0;
            err_count <= '0;
        end else begin
            tx_done_q <= tx_done;
            if (stats_clr) begin
                tx_count  <= '0;
                rx_count  <= '0;
                err_count <= '0;
            end else begin
                tx_count  <= sat_inc(tx_count, tx_event);
                rx_count  <= sat_inc(rx_count, rx_valid);
                err_count <= sat_inc(err_count, rx_frame_err);
            end
        end
    end

    // a full counter only leaves its maximum through a clear
    a_tx_sat: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_count == '1 && !stats_clr) |=> (tx_count == '1));
    a_rx_sat: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_count == '1 && !stats_clr) |=> (rx_count == '1));
    a_err_sat: assert property (@(posedge clk) disable iff (!rst_n)
        (err_count == '1 && !stats_clr) |=> (err_count == '1));

endmodule

`default_nettype wire

/* uart_tx.sv */
// 8N1 transmitter with programmable bit time and start/done status
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [baud_w-1:0] baud_div,   // bit time minus one
    input  logic              start_tx,   // single-cycle strobe
    input  logic [data_w-1:0] data_in,
    output logic              tx_pin,
    output logic              tx_started,
    output logic              tx_done
);

    localparam int idx_w = $clog2(data_w);

    uart_state_t       state;
    logic [baud_w-1:0] bit_timer;
    logic [idx_w-1:0]  bit_idx;
    logic [idx_w-1:0]  next_idx;
    logic [data_w-1:0] data_latch;
    logic              bit_end;   // last cycle of the current bit
    logic              accept;    // strobe taken while idle

    assign bit_end  = (bit_timer == '0);
    assign accept   = (state == st_idle) && start_tx;
    assign next_idx = bit_idx + 1'b1;

    // byte captured once per frame
    always_ff @(posedge clk) begin
        if (accept) begin
            data_latch <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            bit_timer  <= '0;
            bit_idx    <= '0;
            tx_pin     <= 1'b1;
            tx_started <= 1'b0;
            tx_done    <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (start_tx) begin
                        state      <= st_start;
                        bit_timer  <= baud_div;
                        bit_idx    <= '0;
                        tx_pin     <= 1'b0; // start bit from next cycle
                        tx_started <= 1'b1;
                        tx_done    <= 1'b0;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state     <= st_data;
                        bit_timer <= baud_div;
                        tx_pin    <= data_latch[0]; // lsb goes first
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        bit_timer <= baud_div;
                        if (bit_idx == idx_w'(data_w - 1)) begin
                            state  <= st_stop;
                            tx_pin <= 1'b1; // stop bit
                        end else begin
                            bit_idx <= next_idx;
                            tx_pin  <= data_latch[next_idx];
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        state      <= st_idle;
                        tx_started <= 1'b0;
                        tx_done    <= 1'b1; // frame complete
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // status flags are mutually exclusive for the whole frame
    a_status_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_started && tx_done));

    // line rests high between frames
    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle) |-> tx_pin);

endmodule

`default_nettype wire
